/* dataflow.f */
logic/dataflow_pkg.sv
logic/immediate_extender.sv
logic/register_file.sv
logic/alu.sv
logic/dataflow.sv
bench/dataflow_tb.sv

/* Makefile */
# Verilator build and run of the dataflow testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, pass decided from sim.log"
	@echo "  clean  remove the build folder and the log"

obj_dir/Vdataflow_tb: dataflow.f logic/*.sv bench/*.sv
	verilator --binary --timing -j 0 --top-module dataflow_tb -f dataflow.f

test: obj_dir/Vdataflow_tb
	./obj_dir/Vdataflow_tb | tee sim.log
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/dataflow_tb.sv */
// Testbench for the RV64I datapath
// Acts as the control unit, applying a table of instructions and strobes,
// and checks each cycle against a shadow register file, PC and ALU model
`default_nettype none

module dataflow_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [dataflow_pkg::xlen-1:0] word_t;

    // Strobes of one row except pc_src
    typedef struct packed {
        logic       alua;
        logic       alub;
        logic       aluy;
        logic [2:0] op;
        logic       cin;
        logic       arith;
        logic       alupc;
        logic [1:0] wb;
        logic       we;
    } ctrl_t;

    logic                 clock = 1'b0;
    logic                 rst;
    dataflow_pkg::instr_t instruction;
    word_t                read_data;
    logic                 alua_src;
    logic                 alub_src;
    logic                 aluy_src;
    logic [2:0]           alu_src;
    logic                 carry_in;
    logic                 arithmetic;
    logic                 alupc_src;
    logic                 pc_src;
    logic                 pc_enable;
    logic [1:0]           write_register_src;
    logic                 write_register_enable;
    word_t                instruction_address;
    word_t                data_address;
    word_t                write_data;
    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic                 funct7;
    logic                 zero;
    logic                 negative;
    logic                 carry_out;
    logic                 overflow;
    word_t                db_reg_data;

    // Table and shadow state
    string       names [$];
    logic [31:0] words [$];
    word_t       imms  [$];
    ctrl_t       ctrls [$];
    word_t       sreg  [0:31];
    word_t       spc;
    int          cycles = 0;
    int          cycle_limit = 1000;

    dataflow #(.reset_address('0)) UUT (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic word_t model_alu(word_t a, word_t b, logic [2:0] op,
                                        logic cin, logic arith, logic word);
        word_t       r;
        logic [31:0] lo;
        case (op)
            dataflow_pkg::alu_add:  r = cin ? a - b : a + b;
            dataflow_pkg::alu_sll:  r = word ? {32'b0, a[31:0] << b[4:0]} : a << b[5:0];
            dataflow_pkg::alu_slt:  r = {63'b0, $signed(a) < $signed(b)};
            dataflow_pkg::alu_sltu: r = {63'b0, a < b};
            dataflow_pkg::alu_xor:  r = a ^ b;
            dataflow_pkg::alu_or:   r = a | b;
            dataflow_pkg::alu_and:  r = a & b;
            default: begin
                if (word) begin
                    if (arith) lo = $signed(a[31:0]) >>> b[4:0];
                    else       lo = a[31:0] >> b[4:0];
                    r = {32'b0, lo};
                end else if (arith) begin
                    r = $signed(a) >>> b[5:0];
                end else begin
                    r = a >> b[5:0];
                end
            end
        endcase
        return word ? {{32{r[31]}}, r[31:0]} : r;
    endfunction

    // Flags as {zero, negative, carry_out, overflow}
    function automatic logic [3:0] model_flags(word_t a, word_t b, logic cin);
        word_t s;
        logic  c;
        logic  v;
        if (cin) begin
            s = a - b;
            c = (a >= b);
            v = (a[63] != b[63]) && (s[63] != a[63]);
        end else begin
            {c, s} = {1'b0, a} + {1'b0, b};
            v = (a[63] == b[63]) && (s[63] != a[63]);
        end
        return {s == '0, s[63], c, v};
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, logic [3:0] fl);
        case (f3)
            3'b000:  return fl[3];
            3'b001:  return !fl[3];
            3'b100:  return fl[2] ^ fl[0];
            3'b101:  return !(fl[2] ^ fl[0]);
            3'b110:  return !fl[1];
            3'b111:  return fl[1];
            default: return 1'b0;
        endcase
    endfunction

    task automatic report_mismatch(string name, string what, word_t exp, word_t act);
        $display("MISMATCH %s %s: expected %h, actual %h", name, what, exp, act);
        $display("CHECKS FAILED");
        $fatal(1, "first mismatch ends the run");
    endtask

    task automatic check_word(string name, string what, word_t exp, word_t act);
        if (act !== exp) report_mismatch(name, what, exp, act);
    endtask

    task automatic check_flag(string name, string what, logic exp, logic act);
        if (act !== exp) report_mismatch(name, what, word_t'(exp), word_t'(act));
    endtask

    // Decode outputs against the fixed RISC-V bit positions
    task automatic check_fields(string name, dataflow_pkg::instr_t ins);
        if (opcode !== ins[6:0])
            report_mismatch(name, "opcode", word_t'(ins[6:0]), word_t'(opcode));
        if (funct3 !== ins[14:12])
            report_mismatch(name, "funct3", word_t'(ins[14:12]), word_t'(funct3));
        if (funct7 !== ins[30])
            report_mismatch(name, "funct7", word_t'(ins[30]), word_t'(funct7));
    endtask

    function automatic ctrl_t alu_ctrl(int alub, int word, int fn, int cin, int arith);
        return {1'b0, 1'(alub), 1'(word), 3'(fn), 1'(cin), 1'(arith), 1'b0,
                dataflow_pkg::wb_alu, 1'b1};
    endfunction

    function automatic ctrl_t make_ctrl(int alua, int alub, int alupc, int cin,
                                        logic [1:0] wb, int we);
        return {1'(alua), 1'(alub), 1'b0, dataflow_pkg::alu_add, 1'(cin), 1'b0,
                1'(alupc), wb, 1'(we)};
    endfunction

    task automatic add_row(string name, logic [31:0] word, word_t imm, ctrl_t c);
        names.push_back(name);
        words.push_back(word);
        imms.push_back(imm);
        ctrls.push_back(c);
    endtask

    // Sub and the compares need carry_in and funct7 bit 5 picks sub or sra
    task automatic r_row(string name, int f7, int rs2, int rs1, int f3, int rd, int word);
        logic [2:0] fn;
        logic       alt;
        fn  = 3'(f3);
        alt = (f7 == 'h20);
        add_row(name, {7'(f7), 5'(rs2), 5'(rs1), fn, 5'(rd),
                       (word != 0) ? dataflow_pkg::op_reg_w : dataflow_pkg::op_reg}, '0,
                alu_ctrl(0, word, fn, (fn == 0 && alt) || fn == 2 || fn == 3,
                         fn == 5 && alt));
    endtask

    task automatic i_row(string name, int imm, int rs1, int f3, int rd, int word);
        logic [11:0] i12;
        logic [2:0]  fn;
        i12 = 12'(imm);
        fn  = 3'(f3);
        add_row(name, {i12, 5'(rs1), fn, 5'(rd),
                       (word != 0) ? dataflow_pkg::op_imm_w : dataflow_pkg::op_imm},
                {{52{i12[11]}}, i12},
                alu_ctrl(1, word, fn, fn == 2 || fn == 3, fn == 5 && i12[10]));
    endtask

    task automatic b_row(string name, int off, int rs1, int rs2, int f3);
        logic [12:0] o;
        o = 13'(off);
        add_row(name, {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11],
                       dataflow_pkg::op_branch}, {{51{o[12]}}, o},
                make_ctrl(0, 0, 0, 1, dataflow_pkg::wb_alu, 0));
    endtask

    task automatic build_table();
        int unsigned r;
        for (int k = 1; k <= 8; k++) begin
            r = $urandom;
            i_row("addi_fill", int'(r[11:0]), 0, 0, k, 0);
        end
        i_row("slli", 37, 3, 1, 3, 0);
        r_row("add", 0, 2, 1, 0, 9, 0);
        r_row("sub", 'h20, 4, 3, 0, 10, 0);
        r_row("slt", 0, 2, 1, 2, 11, 0);
        r_row("sltu", 0, 4, 3, 3, 12, 0);
        r_row("xor", 0, 6, 5, 4, 13, 0);
        r_row("or", 0, 6, 5, 6, 14, 0);
        r_row("and", 0, 6, 5, 7, 15, 0);
        r_row("sll", 0, 2, 3, 1, 16, 0);
        r_row("srl", 0, 2, 3, 5, 17, 0);
        r_row("sra", 'h20, 2, 3, 5, 18, 0);
        i_row("srai", 'h403, 3, 5, 19, 0);
        i_row("sltiu", 'hfff, 1, 3, 20, 0);
        r_row("addw", 0, 9, 3, 0, 21, 1);
        r_row("subw", 'h20, 1, 3, 0, 22, 1);
        r_row("sllw", 0, 2, 1, 1, 23, 1);
        r_row("srlw", 0, 2, 3, 5, 24, 1);
        r_row("sraw", 'h20, 2, 3, 5, 25, 1);
        i_row("addiw", 'hffb, 3, 0, 26, 1);
        i_row("sraiw", 'h404, 3, 5, 27, 1);
        // Flags on random register pairs
        for (int k = 0; k < 4; k++) begin
            r = $urandom;
            r_row("sub_flags", 'h20, int'(r[2:0]) + 1, int'(r[6:4]) + 1, 0, 28, 0);
        end
        // Nonzero value aimed at x0, then read back through x0
        i_row("addi_x0", 'h555, 0, 0, 0, 0);
        r_row("read_x0", 0, 0, 0, 0, 28, 0);
        add_row("lui", {20'habcde, 5'd29, dataflow_pkg::op_lui}, 64'hffff_ffff_abcd_e000,
                make_ctrl(0, 1, 0, 0, dataflow_pkg::wb_imm, 1));
        add_row("auipc", {20'h12345, 5'd30, dataflow_pkg::op_auipc}, 64'h1234_5000,
                make_ctrl(1, 1, 0, 0, dataflow_pkg::wb_alu, 1));
        // Offset 0x40 split over the J fields
        add_row("jal", {1'b0, 10'h020, 1'b0, 8'h00, 5'd1, dataflow_pkg::op_jal}, 64'h40,
                make_ctrl(0, 1, 0, 0, dataflow_pkg::wb_pc4, 1));
        add_row("jalr", {12'h7f5, 5'd3, 3'b000, 5'd2, dataflow_pkg::op_jalr}, 64'h7f5,
                make_ctrl(0, 1, 1, 0, dataflow_pkg::wb_pc4, 1));
        b_row("beq", 16, 5, 5, 0);
        b_row("bne", 16, 5, 5, 1);
        b_row("blt", -8, 6, 7, 4);
        b_row("bge", 12, 6, 7, 5);
        b_row("bltu", 20, 3, 4, 6);
        b_row("bgeu", -12, 3, 4, 7);
        add_row("sd", {7'h00, 5'd5, 5'd10, 3'b011, 5'd8, dataflow_pkg::op_store}, 64'd8,
                make_ctrl(0, 1, 0, 0, dataflow_pkg::wb_alu, 0));
        add_row("ld", {12'hff0, 5'd10, 3'b011, 5'd31, dataflow_pkg::op_load},
                64'hffff_ffff_ffff_fff0, make_ctrl(0, 1, 0, 0, dataflow_pkg::wb_mem, 1));
        r_row("add_load", 0, 1, 31, 0, 9, 0);
    endtask

    initial begin
        dataflow_pkg::instr_t ins;
        ctrl_t                c;
        word_t                a_val;
        word_t                b_val;
        word_t                exp_res;
        word_t                exp_db;
        word_t                target;
        word_t                mem_word;
        logic [3:0]           flags;
        logic                 take;
        int unsigned          seed_out;

        seed_out = $urandom(32'h165aaa4b);
        rst = 1'b1;
        instruction = '0;
        read_data = '0;
        alua_src = 1'b0;
        alub_src = 1'b0;
        aluy_src = 1'b0;
        alu_src = '0;
        carry_in = 1'b0;
        arithmetic = 1'b0;
        alupc_src = 1'b0;
        pc_src = 1'b0;
        pc_enable = 1'b0;
        write_register_src = '0;
        write_register_enable = 1'b0;
        build_table();
        cycle_limit = names.size() + 16 + 20;
        foreach (sreg[k]) sreg[k] = '0;
        spc = '0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        for (int k = 0; k < names.size(); k++) begin
            ins      = words[k];
            c        = ctrls[k];
            a_val    = c.alua ? spc : sreg[ins.r.rs1];
            b_val    = c.alub ? imms[k] : sreg[ins.r.rs2];
            exp_res  = model_alu(a_val, b_val, c.op, c.cin, c.arith, c.aluy);
            flags    = model_flags(a_val, b_val, c.cin);
            mem_word = {$urandom, $urandom};
            case (c.wb)
                dataflow_pkg::wb_mem: exp_db = mem_word;
                dataflow_pkg::wb_pc4: exp_db = spc + 64'd4;
                dataflow_pkg::wb_imm: exp_db = imms[k];
                default:              exp_db = exp_res;
            endcase
            // Jumps always redirect while branches follow the flags
            case (ins.r.opcode)
                dataflow_pkg::op_jal, dataflow_pkg::op_jalr: take = 1'b1;
                dataflow_pkg::op_branch: take = branch_taken(ins.b.funct3, flags);
                default: take = 1'b0;
            endcase
            target = (c.alupc ? sreg[ins.i.rs1] : spc) + imms[k];
            if (c.alupc) target[0] = 1'b0;

            instruction = ins;
            read_data = mem_word;
            alua_src = c.alua;
            alub_src = c.alub;
            aluy_src = c.aluy;
            alu_src = c.op;
            carry_in = c.cin;
            arithmetic = c.arith;
            alupc_src = c.alupc;
            pc_src = take;
            pc_enable = 1'b1;
            write_register_src = c.wb;
            write_register_enable = c.we;
            #1;
            check_word(names[k], "instruction_address", spc, instruction_address);
            check_word(names[k], "db_reg_data", exp_db, db_reg_data);
            check_word(names[k], "data_address", exp_res, data_address);
            check_word(names[k], "write_data", sreg[ins.s.rs2], write_data);
            check_flag(names[k], "zero", flags[3], zero);
            check_flag(names[k], "negative", flags[2], negative);
            check_flag(names[k], "carry_out", flags[1], carry_out);
            check_flag(names[k], "overflow", flags[0], overflow);
            check_fields(names[k], ins);

            if (c.we && ins.r.rd != 5'd0) sreg[ins.r.rd] = exp_db;
            spc = take ? target : spc + 64'd4;
            @(negedge clock);
        end

        pc_enable = 1'b0;
        write_register_enable = 1'b0;
        #1;
        check_word("final", "instruction_address", spc, instruction_address);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/dataflow.sv */
// RV64I datapath
// Program counter, register file, immediate extender and ALU, steered
// by level strobes from an external control unit
`default_nettype none

module dataflow #(
    parameter logic [dataflow_pkg::xlen-1:0] reset_address = '0
) (
    input  logic                          clock,
    input  logic                          rst,
    input  dataflow_pkg::instr_t          instruction,
    input  logic [dataflow_pkg::xlen-1:0] read_data,
    input  logic                          alua_src,
    input  logic                          alub_src,
    input  logic                          aluy_src,
    input  logic [2:0]                    alu_src,
    input  logic                          carry_in,
    input  logic                          arithmetic,
    input  logic                          alupc_src,
    input  logic                          pc_src,
    input  logic                          pc_enable,
    input  logic [1:0]                    write_register_src,
    input  logic                          write_register_enable,
    output logic [dataflow_pkg::xlen-1:0] instruction_address,
    output logic [dataflow_pkg::xlen-1:0] data_address,
    output logic [dataflow_pkg::xlen-1:0] write_data,
    output logic [6:0]                    opcode,
    output logic [2:0]                    funct3,
    output logic                          funct7,
    output logic                          zero,
    output logic                          negative,
    output logic                          carry_out,
    output logic                          overflow,
    output logic [dataflow_pkg::xlen-1:0] db_reg_data
);

    logic [dataflow_pkg::xlen-1:0] pc;
    logic [dataflow_pkg::xlen-1:0] pc_plus4;
    logic [dataflow_pkg::xlen-1:0] target_base;
    logic [dataflow_pkg::xlen-1:0] target_sum;
    logic [dataflow_pkg::xlen-1:0] target;
    logic [dataflow_pkg::xlen-1:0] immediate;
    logic [dataflow_pkg::xlen-1:0] reg_a;
    logic [dataflow_pkg::xlen-1:0] reg_b;
    logic [dataflow_pkg::xlen-1:0] alu_a;
    logic [dataflow_pkg::xlen-1:0] alu_b;
    logic [dataflow_pkg::xlen-1:0] alu_result;

    // Decode fields for the control unit
    assign opcode = instruction.r.opcode;
    assign funct3 = instruction.i.funct3;
    assign funct7 = instruction.r.funct7[5];

    immediate_extender u_immediate_extender (
        .instruction (instruction),
        .immediate   (immediate)
    );

    register_file u_register_file (
        .clock         (clock),
        .rst           (rst),
        .write_enable  (write_register_enable),
        .read_address1 (instruction.r.rs1),
        .read_address2 (instruction.r.rs2),
        .write_address (instruction.r.rd),
        .write_data    (db_reg_data),
        .read_data1    (reg_a),
        .read_data2    (reg_b)
    );

    assign alu_a = alua_src ? pc : reg_a;
    assign alu_b = alub_src ? immediate : reg_b;

    alu u_alu (
        .a          (alu_a),
        .b          (alu_b),
        .operation  (alu_src),
        .carry_in   (carry_in),
        .arithmetic (arithmetic),
        .word_mode  (aluy_src),
        .result     (alu_result),
        .zero       (zero),
        .negative   (negative),
        .carry_out  (carry_out),
        .overflow   (overflow)
    );

    // Jump and branch target, bit 0 dropped for JALR
    assign pc_plus4    = pc + dataflow_pkg::xlen'(4);
    assign target_base = alupc_src ? reg_a : pc;
    assign target_sum  = target_base + immediate;
    assign target      = {target_sum[dataflow_pkg::xlen-1:1], target_sum[0] & ~alupc_src};

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= reset_address;
        end else if (pc_enable) begin
            pc <= pc_src ? target : pc_plus4;
        end
    end

    always_comb begin
        case (write_register_src)
            dataflow_pkg::wb_alu: db_reg_data = alu_result;
            dataflow_pkg::wb_mem: db_reg_data = read_data;
            dataflow_pkg::wb_pc4: db_reg_data = pc_plus4;
            dataflow_pkg::wb_imm: db_reg_data = immediate;
            default:              db_reg_data = alu_result;
        endcase
    end

    assign instruction_address = pc;
    assign data_address        = alu_result;
    assign write_data          = reg_b;

endmodule

`default_nettype wire

/* logic/alu.sv */
// 64-bit integer ALU
// One adder serves add, sub, the set-less-than pair and all four flags.
// Word mode shifts the low word and sign-extends every result from bit 31
`default_nettype none

module alu (
    input  logic [dataflow_pkg::xlen-1:0] a,
    input  logic [dataflow_pkg::xlen-1:0] b,
    input  logic [2:0]                    operation,
    input  logic                          carry_in,
    input  logic                          arithmetic,
    input  logic                          word_mode,
    output logic [dataflow_pkg::xlen-1:0] result,
    output logic                          zero,
    output logic                          negative,
    output logic                          carry_out,
    output logic                          overflow
);

    localparam int msb = dataflow_pkg::xlen - 1;

    logic [msb:0] b_eff;
    logic [msb:0] sum;
    logic [msb:0] raw;
    logic [31:0]  shl_word;
    logic [31:0]  shr_word;
    logic [msb:0] shl_full;
    logic signed [msb:0] sra_full;
    logic [msb:0] shr_full;

    // Subtraction is a + ~b + 1
    assign b_eff = carry_in ? ~b : b;
    assign {carry_out, sum} = {1'b0, a} + {1'b0, b_eff} + {{dataflow_pkg::xlen{1'b0}}, carry_in};

    assign zero     = (sum == '0);
    assign negative = sum[msb];
    assign overflow = (a[msb] == b_eff[msb]) && (sum[msb] != a[msb]);

    // 32-bit shifts use a 5-bit amount
    assign shl_word = a[31:0] << b[4:0];
    assign shr_word = arithmetic ? 32'($signed(a[31:0]) >>> b[4:0])
                                 : (a[31:0] >> b[4:0]);

    assign shl_full = a << b[5:0];
    // Arithmetic shift kept apart so the sign survives the select
    assign sra_full = $signed(a) >>> b[5:0];
    assign shr_full = arithmetic ? sra_full : (a >> b[5:0]);

    always_comb begin
        case (operation)
            dataflow_pkg::alu_add:  raw = sum;
            dataflow_pkg::alu_sll:  raw = word_mode ? {32'b0, shl_word} : shl_full;
            dataflow_pkg::alu_slt:  raw = {{msb{1'b0}}, negative ^ overflow};
            dataflow_pkg::alu_sltu: raw = {{msb{1'b0}}, ~carry_out};
            dataflow_pkg::alu_xor:  raw = a ^ b;
            dataflow_pkg::alu_shr:  raw = word_mode ? {32'b0, shr_word} : shr_full;
            dataflow_pkg::alu_or:   raw = a | b;
            dataflow_pkg::alu_and:  raw = a & b;
            default:                raw = sum;
        endcase
    end

    // W variants keep only the low word, sign-extended
    assign result = word_mode ? {{(dataflow_pkg::xlen-32){raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

/* logic/register_file.sv */
// Integer register file
// 31 writable 64-bit registers plus x0 hardwired to zero,
// two asynchronous read ports and one synchronous write port
`default_nettype none

module register_file (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   write_enable,
    input  logic [dataflow_pkg::reg_addr_bits-1:0] read_address1,
    input  logic [dataflow_pkg::reg_addr_bits-1:0] read_address2,
    input  logic [dataflow_pkg::reg_addr_bits-1:0] write_address,
    input  logic [dataflow_pkg::xlen-1:0]          write_data,
    output logic [dataflow_pkg::xlen-1:0]          read_data1,
    output logic [dataflow_pkg::xlen-1:0]          read_data2
);

    localparam int num_regs = 2 ** dataflow_pkg::reg_addr_bits;

    // No storage behind x0
    logic [dataflow_pkg::xlen-1:0] regs [1:num_regs-1];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int k = 1; k < num_regs; k++) begin
                regs[k] <= '0;
            end
        end else if (write_enable && (write_address != '0)) begin
            regs[write_address] <= write_data;
        end
    end

    always_comb begin
        read_data1 = '0;
        read_data2 = '0;
        if (read_address1 != '0) begin
            read_data1 = regs[read_address1];
        end
        if (read_address2 != '0) begin
            read_data2 = regs[read_address2];
        end
    end

endmodule

`default_nettype wire

/* logic/immediate_extender.sv */
// Immediate extender
// Picks the instruction format from the opcode and assembles the
// sign-extended 64-bit immediate
`default_nettype none

module immediate_extender (
    input  dataflow_pkg::instr_t                  instruction,
    output logic [dataflow_pkg::xlen-1:0]         immediate
);

    always_comb begin
        case (instruction.r.opcode)
            // I-type, shift amounts ride in the low bits
            dataflow_pkg::op_imm, dataflow_pkg::op_imm_w,
            dataflow_pkg::op_load, dataflow_pkg::op_jalr: begin
                immediate = {{(dataflow_pkg::xlen-12){instruction.i.imm_11_0[11]}},
                             instruction.i.imm_11_0};
            end
            dataflow_pkg::op_store: begin
                immediate = {{(dataflow_pkg::xlen-12){instruction.s.imm_11_5[6]}},
                             instruction.s.imm_11_5, instruction.s.imm_4_0};
            end
            dataflow_pkg::op_branch: begin
                immediate = {{(dataflow_pkg::xlen-13){instruction.b.imm_12}},
                             instruction.b.imm_12, instruction.b.imm_11,
                             instruction.b.imm_10_5, instruction.b.imm_4_1, 1'b0};
            end
            dataflow_pkg::op_lui, dataflow_pkg::op_auipc: begin
                immediate = {{(dataflow_pkg::xlen-32){instruction.u.imm_31_12[19]}},
                             instruction.u.imm_31_12, 12'h000};
            end
            dataflow_pkg::op_jal: begin
                immediate = {{(dataflow_pkg::xlen-21){instruction.j.imm_20}},
                             instruction.j.imm_20, instruction.j.imm_19_12,
                             instruction.j.imm_11, instruction.j.imm_10_1, 1'b0};
            end
            // R-type and unknown opcodes carry no immediate
            default: begin
                immediate = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/dataflow_pkg.sv */
// RV64I datapath shared definitions
// Word widths, opcodes, ALU and write-back selectors, and the
// instruction word seen through each base format
`default_nettype none

package dataflow_pkg;

    localparam int xlen          = 64;
    localparam int reg_addr_bits = 5;

    // Base opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_imm_w  = 7'b0011011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_reg_w  = 7'b0111011;

    // ALU selector, same encoding as funct3
    localparam logic [2:0] alu_add  = 3'b000;
    localparam logic [2:0] alu_sll  = 3'b001;
    localparam logic [2:0] alu_slt  = 3'b010;
    localparam logic [2:0] alu_sltu = 3'b011;
    localparam logic [2:0] alu_xor  = 3'b100;
    localparam logic [2:0] alu_shr  = 3'b101;
    localparam logic [2:0] alu_or   = 3'b110;
    localparam logic [2:0] alu_and  = 3'b111;

    // Register write-back source
    localparam logic [1:0] wb_alu = 2'b00;
    localparam logic [1:0] wb_mem = 2'b01;
    localparam logic [1:0] wb_pc4 = 2'b10;
    localparam logic [1:0] wb_imm = 2'b11;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, six ways to read it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

endpackage

`default_nettype wire
